//--- include/aurora_link_defines.svh
`ifndef AURORA_LINK_DEFINES_SVH
`define AURORA_LINK_DEFINES_SVH

// register word offsets on the control bus
`define REG_LINK_CONTROL     2'd0
`define REG_LINK_STATUS      2'd1
`define REG_LINK_TUNING      2'd2
`define REG_LINK_DMONITOR    2'd3

// link control register bits
`define CTRL_LINK_RESET_BIT  0
`define CTRL_GT_RESET_BIT    1
`define CTRL_POWERDOWN_BIT   3
`define CTRL_LOOPBACK_LSB    4
// write-only bit that pulses the sticky clear
`define CTRL_LINKERR_CLR_BIT 31

// transmitter tuning fields in byte lanes 0 to 2
`define TUNE_DIFFCTRL_LSB    0
`define TUNE_PRECURSOR_LSB   8
`define TUNE_POSTCURSOR_LSB  16

// status register bits
`define STAT_LANE_UP         0
`define STAT_CHANNEL_UP      1
`define STAT_TX_RESETDONE    4
`define STAT_RX_RESETDONE    5
// sticky link errors
`define STAT_HARD_ERR        8
`define STAT_SOFT_ERR        9
`define STAT_FRAME_ERR       10
// sticky overflow flags
`define STAT_RX_OVF          16
`define STAT_UFC_RX_OVF      17

// field widths
`define WORD_W               32
`define REG_SEL_W            2
`define BYTE_EN_W            4
`define DMON_W               16
`define LOOPBACK_W           3
`define DIFFCTRL_W           4
`define CURSOR_W             5

// swing code out of reset
`define DIFFCTRL_DEFAULT     4'd8

`endif

//--- verilog/aurora_link_pkg.sv
`default_nettype none

`include "aurora_link_defines.svh"

package aurora_link_pkg;

    // bus and register word
    typedef logic [`WORD_W-1:0] word_t;

    // word offset into the four registers
    typedef logic [`REG_SEL_W-1:0] reg_sel_t;

    // byte selects on a bus write
    typedef logic [`BYTE_EN_W-1:0] byte_en_t;

    // tx byte keep, one bit per byte of word_t
    typedef logic [`WORD_W/8-1:0] keep_t;

    // digital monitor value from the transceiver
    typedef logic [`DMON_W-1:0] dmon_t;

    // transceiver loopback mode
    typedef logic [`LOOPBACK_W-1:0] loopback_t;

    // tx differential swing code
    typedef logic [`DIFFCTRL_W-1:0] diffctrl_t;

    // pre/postcursor emphasis code
    typedef logic [`CURSOR_W-1:0] cursor_t;

    // register bus handshake states
    typedef enum logic [0:0] {
        BUS_IDLE = 1'b0,
        BUS_ACK  = 1'b1
    } bus_state_t;

endpackage

`default_nettype wire

//--- verilog/link_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "aurora_link_defines.svh"

module link_ctrl_regs
    import aurora_link_pkg::*;
(
    input  wire logic      user_clk,
    input  wire logic      linkerr_reset_userclk,
    input  wire logic      wb_cyc_i,
    input  wire logic      wb_stb_i,
    input  wire logic      wb_we_i,
    input  wire reg_sel_t  wb_adr_i,
    input  wire byte_en_t  wb_sel_i,
    input  wire word_t     wb_dat_i,
    input  wire word_t     status_i,
    input  wire dmon_t     dmonitor_i,
    output word_t          wb_dat_o,
    output logic           wb_ack_o,
    output logic           link_reset_o,
    output logic           gt_reset_o,
    output logic           powerdown_o,
    output logic           linkerr_clear_o,
    output loopback_t      loopback_o,
    output diffctrl_t      txdiffctrl_o,
    output cursor_t        txprecursor_o,
    output cursor_t        txpostcursor_o
);

    // bus handshake state
    bus_state_t state_q;
    // request seen on the bus
    logic       bus_req;
    // write completes on the edge closing the ack cycle
    logic       wr_done;
    // read data held for the whole ack cycle
    word_t      rd_data_q;

    // control fields
    logic       link_reset_q;
    logic       gt_reset_q;
    logic       powerdown_q;
    loopback_t  loopback_q;
    logic       linkerr_clear_q;

    // tuning fields
    diffctrl_t  diffctrl_q;
    cursor_t    precursor_q;
    cursor_t    postcursor_q;

    // assembled register images
    word_t      ctrl_word;
    word_t      tune_word;
    word_t      dmon_word;
    word_t      rd_mux;

    assign bus_req = wb_cyc_i && wb_stb_i;
    assign wr_done = (state_q == BUS_ACK) && bus_req && wb_we_i;

    // control image, clear bit always reads back as zero
    always_comb begin
        ctrl_word = '0;
        ctrl_word[`CTRL_LINK_RESET_BIT] = link_reset_q;
        ctrl_word[`CTRL_GT_RESET_BIT] = gt_reset_q;
        ctrl_word[`CTRL_POWERDOWN_BIT] = powerdown_q;
        ctrl_word[`CTRL_LOOPBACK_LSB +: `LOOPBACK_W] = loopback_q;
    end

    // tuning image, spare bits in each byte are zero
    always_comb begin
        tune_word = '0;
        tune_word[`TUNE_DIFFCTRL_LSB +: `DIFFCTRL_W] = diffctrl_q;
        tune_word[`TUNE_PRECURSOR_LSB +: `CURSOR_W] = precursor_q;
        tune_word[`TUNE_POSTCURSOR_LSB +: `CURSOR_W] = postcursor_q;
    end

    // monitor value zero-extended to a full word
    assign dmon_word = {{(`WORD_W-`DMON_W){1'b0}}, dmonitor_i};

    // pick the addressed register
    always_comb begin
        case (wb_adr_i)
            `REG_LINK_CONTROL:  rd_mux = ctrl_word;
            `REG_LINK_STATUS:   rd_mux = status_i;
            `REG_LINK_TUNING:   rd_mux = tune_word;
            default:            rd_mux = dmon_word;
        endcase
    end

    // two-state handshake, ack one cycle after the request is sampled
    always_ff @(posedge user_clk) begin
        if (linkerr_reset_userclk) begin
            state_q <= BUS_IDLE;
            rd_data_q <= '0;
        end else begin
            case (state_q)
                BUS_IDLE: begin
                    if (bus_req) begin
                        state_q <= BUS_ACK;
                        // snapshot taken when the request is first seen
                        if (!wb_we_i) begin
                            rd_data_q <= rd_mux;
                        end
                    end
                end
                default: begin
                    // back to idle, master must drop the request here
                    state_q <= BUS_IDLE;
                end
            endcase
        end
    end

    // register writes, byte lanes gated by the selects
    always_ff @(posedge user_clk) begin
        if (linkerr_reset_userclk) begin
            link_reset_q <= 1'b0;
            gt_reset_q <= 1'b0;
            powerdown_q <= 1'b0;
            loopback_q <= '0;
            linkerr_clear_q <= 1'b0;
            diffctrl_q <= `DIFFCTRL_DEFAULT;
            precursor_q <= '0;
            postcursor_q <= '0;
        end else begin
            // clear pulse lasts a single cycle
            linkerr_clear_q <= 1'b0;
            if (wr_done && wb_adr_i == `REG_LINK_CONTROL) begin
                if (wb_sel_i[0]) begin
                    link_reset_q <= wb_dat_i[`CTRL_LINK_RESET_BIT];
                    gt_reset_q <= wb_dat_i[`CTRL_GT_RESET_BIT];
                    powerdown_q <= wb_dat_i[`CTRL_POWERDOWN_BIT];
                    loopback_q <= wb_dat_i[`CTRL_LOOPBACK_LSB +: `LOOPBACK_W];
                end
                if (wb_sel_i[3]) begin
                    linkerr_clear_q <= wb_dat_i[`CTRL_LINKERR_CLR_BIT];
                end
            end
            if (wr_done && wb_adr_i == `REG_LINK_TUNING) begin
                if (wb_sel_i[0]) begin
                    diffctrl_q <= wb_dat_i[`TUNE_DIFFCTRL_LSB +: `DIFFCTRL_W];
                end
                if (wb_sel_i[1]) begin
                    precursor_q <= wb_dat_i[`TUNE_PRECURSOR_LSB +: `CURSOR_W];
                end
                if (wb_sel_i[2]) begin
                    postcursor_q <= wb_dat_i[`TUNE_POSTCURSOR_LSB +: `CURSOR_W];
                end
            end
        end
    end

    assign wb_ack_o = (state_q == BUS_ACK);
    assign wb_dat_o = rd_data_q;

    // fields straight out to the transceiver
    assign link_reset_o = link_reset_q;
    assign gt_reset_o = gt_reset_q;
    assign powerdown_o = powerdown_q;
    assign loopback_o = loopback_q;
    assign linkerr_clear_o = linkerr_clear_q;
    assign txdiffctrl_o = diffctrl_q;
    assign txprecursor_o = precursor_q;
    assign txpostcursor_o = postcursor_q;

endmodule

`default_nettype wire

//--- verilog/link_status_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "aurora_link_defines.svh"

module link_status_capture
    import aurora_link_pkg::*;
(
    input  wire logic user_clk,
    input  wire logic linkerr_reset_userclk,
    input  wire logic linkerr_clear_i,
    input  wire logic lane_up_i,
    input  wire logic channel_up_i,
    input  wire logic tx_resetdone_i,
    input  wire logic rx_resetdone_i,
    input  wire logic hard_err_i,
    input  wire logic soft_err_i,
    input  wire logic frame_err_i,
    input  wire logic rx_overflow_i,
    input  wire logic ufc_rx_overflow_i,
    output word_t     status_o
);

    // captured status word, unused bits never leave zero
    word_t status_q;

    // next value of a sticky bit, a clear beats a set
    function automatic logic sticky_next(
        input logic cur,
        input logic set,
        input logic clr
    );
        sticky_next = !clr && (cur || set);
    endfunction

    always_ff @(posedge user_clk) begin
        if (linkerr_reset_userclk) begin
            status_q <= '0;
        end else begin
            // level bits, one cycle behind the core
            status_q[`STAT_LANE_UP] <= lane_up_i;
            status_q[`STAT_CHANNEL_UP] <= channel_up_i;
            status_q[`STAT_TX_RESETDONE] <= tx_resetdone_i;
            status_q[`STAT_RX_RESETDONE] <= rx_resetdone_i;

            // link errors held until cleared
            status_q[`STAT_HARD_ERR] <=
                sticky_next(status_q[`STAT_HARD_ERR], hard_err_i, linkerr_clear_i);
            status_q[`STAT_SOFT_ERR] <=
                sticky_next(status_q[`STAT_SOFT_ERR], soft_err_i, linkerr_clear_i);
            status_q[`STAT_FRAME_ERR] <=
                sticky_next(status_q[`STAT_FRAME_ERR], frame_err_i, linkerr_clear_i);

            // receive overflows, same clear as the errors
            status_q[`STAT_RX_OVF] <=
                sticky_next(status_q[`STAT_RX_OVF], rx_overflow_i, linkerr_clear_i);
            status_q[`STAT_UFC_RX_OVF] <=
                sticky_next(status_q[`STAT_UFC_RX_OVF], ufc_rx_overflow_i, linkerr_clear_i);
        end
    end

    assign status_o = status_q;

endmodule

`default_nettype wire

//--- verilog/ufc_tx_merge.sv
`timescale 1ns/1ps
`default_nettype none

module ufc_tx_merge
    import aurora_link_pkg::*;
(
    input  wire logic  user_clk,
    input  wire logic  linkerr_reset_userclk,
    input  wire logic  s_axis_tvalid_i,
    input  wire logic  s_axis_tlast_i,
    input  wire logic  tx_tready_i,
    input  wire logic  ufc_tvalid_i,
    input  wire logic  ufc_tready_i,
    input  wire word_t s_axis_tdata_i,
    input  wire word_t ufc_tdata_i,
    input  wire keep_t s_axis_tkeep_i,
    output logic       s_axis_tready_o,
    output logic       tx_tvalid_o,
    output logic       tx_tlast_o,
    output logic       ufc_tvalid_o,
    output logic       ufc_src_tready_o,
    output word_t      tx_tdata_o,
    output keep_t      tx_tkeep_o
);

    // high in the cycle the core samples the UFC word
    logic ufc_cycle_q;

    // core took the request, next cycle carries the word
    always_ff @(posedge user_clk) begin
        if (linkerr_reset_userclk) begin
            ufc_cycle_q <= 1'b0;
        end else begin
            ufc_cycle_q <= ufc_tvalid_o && ufc_tready_i;
        end
    end

    // request masked during the data cycle, so the flag never lasts
    // more than one cycle and messages end up two cycles apart
    assign ufc_tvalid_o = ufc_tvalid_i && !ufc_cycle_q;

    // source ack held back to the data cycle
    assign ufc_src_tready_o = ufc_cycle_q;

    // user path handshake goes straight through
    assign tx_tvalid_o = s_axis_tvalid_i;
    assign s_axis_tready_o = tx_tready_i;

    // core drops ready while it owns the slot for UFC
    // keep and last only matter on user beats
    assign tx_tdata_o = tx_tready_i ? s_axis_tdata_i : ufc_tdata_i;
    assign tx_tkeep_o = s_axis_tkeep_i;
    assign tx_tlast_o = s_axis_tlast_i;

endmodule

`default_nettype wire

//--- verilog/aurora_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module aurora_link_top
    import aurora_link_pkg::*;
(
    input  wire logic      user_clk,
    input  wire logic      linkerr_reset_userclk,
    // register bus
    input  wire logic      wb_cyc_i,
    input  wire logic      wb_stb_i,
    input  wire logic      wb_we_i,
    input  wire reg_sel_t  wb_adr_i,
    input  wire byte_en_t  wb_sel_i,
    input  wire word_t     wb_dat_i,
    output word_t          wb_dat_o,
    output logic           wb_ack_o,
    // core status
    input  wire logic      lane_up_i,
    input  wire logic      channel_up_i,
    input  wire logic      tx_resetdone_i,
    input  wire logic      rx_resetdone_i,
    input  wire logic      hard_err_i,
    input  wire logic      soft_err_i,
    input  wire logic      frame_err_i,
    input  wire logic      rx_overflow_i,
    input  wire logic      ufc_rx_overflow_i,
    input  wire dmon_t     dmonitor_i,
    // core control and tuning
    output logic           link_reset_o,
    output logic           gt_reset_o,
    output logic           powerdown_o,
    output loopback_t      loopback_o,
    output diffctrl_t      txdiffctrl_o,
    output cursor_t        txprecursor_o,
    output cursor_t        txpostcursor_o,
    // user tx stream
    input  wire logic      s_axis_tvalid_i,
    input  wire logic      s_axis_tlast_i,
    input  wire word_t     s_axis_tdata_i,
    input  wire keep_t     s_axis_tkeep_i,
    output logic           s_axis_tready_o,
    // merged stream to the core
    input  wire logic      tx_tready_i,
    output logic           tx_tvalid_o,
    output logic           tx_tlast_o,
    output word_t          tx_tdata_o,
    output keep_t          tx_tkeep_o,
    // UFC source and core request
    input  wire logic      ufc_tvalid_i,
    input  wire word_t     ufc_tdata_i,
    output logic           ufc_s_tready_o,
    output logic           ufc_core_tvalid_o,
    input  wire logic      ufc_tready_i
);

    // registered status into the read mux
    word_t status_word;
    // one-cycle clear of the sticky flags
    logic  linkerr_clear;

    link_ctrl_regs u_regs (
        .user_clk              (user_clk),
        .linkerr_reset_userclk (linkerr_reset_userclk),
        .wb_cyc_i              (wb_cyc_i),
        .wb_stb_i              (wb_stb_i),
        .wb_we_i               (wb_we_i),
        .wb_adr_i              (wb_adr_i),
        .wb_sel_i              (wb_sel_i),
        .wb_dat_i              (wb_dat_i),
        .status_i              (status_word),
        .dmonitor_i            (dmonitor_i),
        .wb_dat_o              (wb_dat_o),
        .wb_ack_o              (wb_ack_o),
        .link_reset_o          (link_reset_o),
        .gt_reset_o            (gt_reset_o),
        .powerdown_o           (powerdown_o),
        .linkerr_clear_o       (linkerr_clear),
        .loopback_o            (loopback_o),
        .txdiffctrl_o          (txdiffctrl_o),
        .txprecursor_o         (txprecursor_o),
        .txpostcursor_o        (txpostcursor_o)
    );

    link_status_capture u_status (
        .user_clk              (user_clk),
        .linkerr_reset_userclk (linkerr_reset_userclk),
        .linkerr_clear_i       (linkerr_clear),
        .lane_up_i             (lane_up_i),
        .channel_up_i          (channel_up_i),
        .tx_resetdone_i        (tx_resetdone_i),
        .rx_resetdone_i        (rx_resetdone_i),
        .hard_err_i            (hard_err_i),
        .soft_err_i            (soft_err_i),
        .frame_err_i           (frame_err_i),
        .rx_overflow_i         (rx_overflow_i),
        .ufc_rx_overflow_i     (ufc_rx_overflow_i),
        .status_o              (status_word)
    );

    ufc_tx_merge u_merge (
        .user_clk              (user_clk),
        .linkerr_reset_userclk (linkerr_reset_userclk),
        .s_axis_tvalid_i       (s_axis_tvalid_i),
        .s_axis_tlast_i        (s_axis_tlast_i),
        .tx_tready_i           (tx_tready_i),
        .ufc_tvalid_i          (ufc_tvalid_i),
        .ufc_tready_i          (ufc_tready_i),
        .s_axis_tdata_i        (s_axis_tdata_i),
        .ufc_tdata_i           (ufc_tdata_i),
        .s_axis_tkeep_i        (s_axis_tkeep_i),
        .s_axis_tready_o       (s_axis_tready_o),
        .tx_tvalid_o           (tx_tvalid_o),
        .tx_tlast_o            (tx_tlast_o),
        .ufc_tvalid_o          (ufc_core_tvalid_o),
        .ufc_src_tready_o      (ufc_s_tready_o),
        .tx_tdata_o            (tx_tdata_o),
        .tx_tkeep_o            (tx_tkeep_o)
    );

endmodule

`default_nettype wire

//--- sim/tb_aurora_link.sv
`timescale 1ns/1ps
`default_nettype none

`include "aurora_link_defines.svh"

module tb_aurora_link;

    // cycles allowed for a bus ack or a core request
    localparam int ACK_TIMEOUT = 20;
    localparam int READY_TIMEOUT = 20;

    logic        user_clk;
    logic        linkerr_reset_userclk;
    // register bus
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [1:0]  wb_adr_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    // core status
    logic        lane_up_i;
    logic        channel_up_i;
    logic        tx_resetdone_i;
    logic        rx_resetdone_i;
    logic        hard_err_i;
    logic        soft_err_i;
    logic        frame_err_i;
    logic        rx_overflow_i;
    logic        ufc_rx_overflow_i;
    logic [15:0] dmonitor_i;
    // control and tuning out to the core
    logic        link_reset_o;
    logic        gt_reset_o;
    logic        powerdown_o;
    logic [2:0]  loopback_o;
    logic [3:0]  txdiffctrl_o;
    logic [4:0]  txprecursor_o;
    logic [4:0]  txpostcursor_o;
    // user stream and merged stream
    logic        s_axis_tvalid_i;
    logic        s_axis_tlast_i;
    logic [31:0] s_axis_tdata_i;
    logic [3:0]  s_axis_tkeep_i;
    logic        s_axis_tready_o;
    logic        tx_tready_i;
    logic        tx_tvalid_o;
    logic        tx_tlast_o;
    logic [31:0] tx_tdata_o;
    logic [3:0]  tx_tkeep_o;
    // UFC source and core side
    logic        ufc_tvalid_i;
    logic [31:0] ufc_tdata_i;
    logic        ufc_s_tready_o;
    logic        ufc_core_tvalid_o;
    logic        ufc_tready_i;

    int          n_checks;
    int          n_errors;
    int          n_ops;
    int          n_idle;
    int          n_fields;
    int          fd;
    string       line;
    logic [31:0] rnd;
    logic [31:0] op;
    logic [31:0] off;
    logic [31:0] sel;
    logic [31:0] data;
    logic [31:0] exp_val;

    // tb signal names match the top-level ports
    aurora_link_top DUT (.*);

    initial begin
        user_clk = 1'b0;
        forever #2 user_clk = ~user_clk;
    end

    // LCG step for the idle gaps
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // one bus transfer with the request held until ack and one idle cycle after
    task automatic bus_access(
        input  logic        we,
        input  logic [31:0] adr,
        input  logic [31:0] be,
        input  logic [31:0] wdata,
        output logic [31:0] rdata
    );
        logic got_ack;
        got_ack = 1'b0;
        rdata = '0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i = we;
        wb_adr_i = adr[1:0];
        wb_sel_i = be[3:0];
        wb_dat_i = wdata;
        for (int i = 0; i < ACK_TIMEOUT && !got_ack; i++) begin
            @(negedge user_clk);
            got_ack = wb_ack_o;
        end
        assert (got_ack) else begin
            n_errors++;
            $display("timeout waiting for the register bus ack at offset %0h", adr);
        end
        rdata = wb_dat_o;
        // the write lands on the edge that ends the ack cycle
        @(negedge user_clk);
        check_val("wb_ack_o", 32'(wb_ack_o), 32'h0);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        @(negedge user_clk);
    endtask

    // offset 3 loads the monitor value and any other offset the status inputs
    task automatic apply_status(input logic [31:0] adr, input logic [31:0] val);
        if (adr == 32'(`REG_LINK_DMONITOR)) begin
            dmonitor_i = val[15:0];
        end else begin
            lane_up_i = val[`STAT_LANE_UP];
            channel_up_i = val[`STAT_CHANNEL_UP];
            tx_resetdone_i = val[`STAT_TX_RESETDONE];
            rx_resetdone_i = val[`STAT_RX_RESETDONE];
            hard_err_i = val[`STAT_HARD_ERR];
            soft_err_i = val[`STAT_SOFT_ERR];
            frame_err_i = val[`STAT_FRAME_ERR];
            rx_overflow_i = val[`STAT_RX_OVF];
            ufc_rx_overflow_i = val[`STAT_UFC_RX_OVF];
        end
        @(negedge user_clk);
    endtask

    // one user beat with core ready in flags bit 1 and tlast in flags bit 0
    task automatic send_data(
        input logic [31:0] flags,
        input logic [31:0] keep,
        input logic [31:0] word,
        input logic [31:0] exp
    );
        // no beat offered yet
        check_val("tx_tvalid_o", 32'(tx_tvalid_o), 32'h0);
        s_axis_tvalid_i = 1'b1;
        s_axis_tdata_i = word;
        s_axis_tkeep_i = keep[3:0];
        s_axis_tlast_i = flags[0];
        tx_tready_i = flags[1];
        #1;
        check_val("tx_tvalid_o", 32'(tx_tvalid_o), 32'h1);
        check_val("tx_tkeep_o", 32'(tx_tkeep_o), 32'(keep[3:0]));
        check_val("tx_tlast_o", 32'(tx_tlast_o), 32'(flags[0]));
        check_val("s_axis_tready_o", 32'(s_axis_tready_o), 32'(flags[1]));
        check_val("tx_tdata_o", tx_tdata_o, exp);
        @(negedge user_clk);
        s_axis_tvalid_i = 1'b0;
        tx_tready_i = 1'b1;
    endtask

    // core accepts the request and then takes the slot for one cycle
    task automatic send_ufc(input logic [31:0] word, input logic [31:0] exp);
        logic seen;
        seen = 1'b0;
        ufc_tdata_i = word;
        ufc_tvalid_i = 1'b1;
        ufc_tready_i = 1'b1;
        for (int i = 0; i < READY_TIMEOUT && !seen; i++) begin
            #1;
            seen = ufc_core_tvalid_o;
            if (!seen) begin
                @(negedge user_clk);
            end
        end
        assert (seen) else begin
            n_errors++;
            $display("timeout waiting for the UFC request to reach the core");
        end
        @(negedge user_clk);
        // in the data cycle the word rides the bus in place of user data
        // core ready stays high so a second accept would show up
        tx_tready_i = 1'b0;
        #1;
        check_val("ufc_s_tready_o", 32'(ufc_s_tready_o), 32'h1);
        check_val("tx_tdata_o", tx_tdata_o, exp);
        check_val("ufc_core_tvalid_o", 32'(ufc_core_tvalid_o), 32'h0);
        check_val("s_axis_tready_o", 32'(s_axis_tready_o), 32'h0);
        @(negedge user_clk);
        ufc_tvalid_i = 1'b0;
        ufc_tready_i = 1'b0;
        tx_tready_i = 1'b1;
        #1;
        // single-cycle source ack
        check_val("ufc_s_tready_o", 32'(ufc_s_tready_o), 32'h0);
        @(negedge user_clk);
    endtask

    task automatic run_op();
        logic [31:0] rdata;
        case (op)
            32'd0: bus_access(1'b1, off, sel, data, rdata);
            32'd1: begin
                bus_access(1'b0, off, sel, data, rdata);
                check_val("wb_dat_o", rdata, exp_val);
                // ports follow the fields that were read back
                if (off == 32'(`REG_LINK_CONTROL)) begin
                    check_val("link_reset_o", 32'(link_reset_o),
                              32'(exp_val[`CTRL_LINK_RESET_BIT]));
                    check_val("gt_reset_o", 32'(gt_reset_o), 32'(exp_val[`CTRL_GT_RESET_BIT]));
                    check_val("powerdown_o", 32'(powerdown_o),
                              32'(exp_val[`CTRL_POWERDOWN_BIT]));
                    check_val("loopback_o", 32'(loopback_o),
                              32'(exp_val[`CTRL_LOOPBACK_LSB +: `LOOPBACK_W]));
                end
                if (off == 32'(`REG_LINK_TUNING)) begin
                    check_val("txdiffctrl_o", 32'(txdiffctrl_o),
                              32'(exp_val[`TUNE_DIFFCTRL_LSB +: `DIFFCTRL_W]));
                    check_val("txprecursor_o", 32'(txprecursor_o),
                              32'(exp_val[`TUNE_PRECURSOR_LSB +: `CURSOR_W]));
                    check_val("txpostcursor_o", 32'(txpostcursor_o),
                              32'(exp_val[`TUNE_POSTCURSOR_LSB +: `CURSOR_W]));
                end
            end
            32'd2: apply_status(off, data);
            32'd3: send_data(off, sel, data, exp_val);
            32'd4: send_ufc(data, exp_val);
            default: begin
                assert (1'b0) else begin
                    n_errors++;
                    $display("unknown opcode %0h in the vector file", op);
                end
            end
        endcase
    endtask

    initial begin
        n_checks = 0;
        n_errors = 0;
        n_ops = 0;
        rnd = 32'd82571;
        linkerr_reset_userclk = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_sel_i = '0;
        wb_dat_i = '0;
        lane_up_i = 1'b0;
        channel_up_i = 1'b0;
        tx_resetdone_i = 1'b0;
        rx_resetdone_i = 1'b0;
        hard_err_i = 1'b0;
        soft_err_i = 1'b0;
        frame_err_i = 1'b0;
        rx_overflow_i = 1'b0;
        ufc_rx_overflow_i = 1'b0;
        dmonitor_i = '0;
        s_axis_tvalid_i = 1'b0;
        s_axis_tlast_i = 1'b0;
        s_axis_tdata_i = '0;
        s_axis_tkeep_i = '0;
        tx_tready_i = 1'b1;
        ufc_tvalid_i = 1'b0;
        ufc_tdata_i = '0;
        ufc_tready_i = 1'b0;

        repeat (3) @(negedge user_clk);
        linkerr_reset_userclk = 1'b0;
        #1;
        // outputs out of reset with the swing code at 8
        check_val("wb_ack_o", 32'(wb_ack_o), 32'h0);
        check_val("ufc_s_tready_o", 32'(ufc_s_tready_o), 32'h0);
        check_val("link_reset_o", 32'(link_reset_o), 32'h0);
        check_val("txdiffctrl_o", 32'(txdiffctrl_o), 32'h8);
        @(negedge user_clk);

        fd = $fopen("sim/aurora_link_tests.txt", "r");
        assert (fd != 0) else begin
            n_errors++;
            $display("could not open the test vector file");
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // comment and blank lines scan no fields
                n_fields = $sscanf(line, "%h %h %h %h %h", op, off, sel, data, exp_val);
                if (n_fields == 5) begin
                    n_ops++;
                    run_op();
                    rnd = lcg_next(rnd);
                    n_idle = 32'(rnd[17:16]);
                    for (int i = 0; i < n_idle; i++) begin
                        @(negedge user_clk);
                    end
                end
            end
            $fclose(fd);
        end
        assert (n_ops > 0) else begin
            n_errors++;
            $display("no operations were read from the vector file");
        end

        $display("tb_aurora_link: %0d ops, %0d checks, %0d errors", n_ops, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/aurora_link_tests.txt
# op offset select data expected, all hex; op 0 write, 1 read-expect, 2 set-status, 3 tx-data, 4 ufc
# set-status offset 3 loads the monitor; tx-data offset bit1 is core ready, bit0 is tlast, select is keep
1 0 f 00000000 00000000
1 2 f 00000000 00000008
1 1 f 00000000 00000000
0 0 1 0000003b 00000000
1 0 f 00000000 0000003b
0 0 e ffffffff 00000000
1 0 f 00000000 0000003b
0 0 1 000000f6 00000000
1 0 f 00000000 00000072
0 2 7 ffffffff 00000000
1 2 f 00000000 001f1f0f
0 2 2 00000300 00000000
1 2 f 00000000 001f030f
0 2 5 000a0008 00000000
0 2 8 ffffffff 00000000
1 2 f 00000000 000a0308
2 1 0 00000100 00000000
2 1 0 00000000 00000000
1 1 f 00000000 00000100
2 1 0 00010000 00000000
2 1 0 00000000 00000000
1 1 f 00000000 00010100
0 0 8 80000000 00000000
1 1 f 00000000 00000000
1 0 f 00000000 00000072
2 1 0 00020600 00000000
2 1 0 00000000 00000000
1 1 f 00000000 00020600
0 0 8 80000000 00000000
1 1 f 00000000 00000000
2 1 0 00000033 00000000
2 3 0 0000a5c3 00000000
1 1 f 00000000 00000033
1 3 f 00000000 0000a5c3
3 3 f 11223344 11223344
3 2 3 55667788 55667788
4 0 0 cafe0001 cafe0001
3 0 f 99aabbcc cafe0001
3 2 f 99aabbcc 99aabbcc
4 0 0 0badf00d 0badf00d
3 1 1 deadbeef 0badf00d
3 3 1 deadbeef deadbeef

//--- sources.f
+incdir+include
verilog/aurora_link_pkg.sv
verilog/link_ctrl_regs.sv
verilog/link_status_capture.sv
verilog/ufc_tx_merge.sv
verilog/aurora_link_top.sv
sim/tb_aurora_link.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator from the project root, then run and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_aurora_link \
    -f sources.f -o tb_aurora_link > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_aurora_link > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation gave no result"; exit 1; }
exit 0
